// ==== build.f ====
csr_pkg.sv
csr_access_ctrl.sv
csr_trap_regs.sv
csr_counters.sv
csr_read_mux.sv
csr_unit.sv
tb_clock_gen.sv
csr_unit_tb.sv

// ==== Makefile ====
# Verilator simulation of the CSR unit

.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module csr_unit_tb -f build.f -o csr_unit_sim
	./obj_dir/csr_unit_sim | tee /dev/stderr | grep -qx '>>> PASS'

clean:
	rm -rf obj_dir

// ==== csr_unit_tb.sv ====
/* CSR unit testbench */
`timescale 1ns/1ns
`default_nettype none

module csr_unit_tb;
    import csr_pkg::*;

    localparam int TIMEOUT = 50;
    localparam int HART    = 2;
    // mxl 1 at bit 30, M at bit 12, I at bit 8
    localparam csr_data_t MISA_EXP = (32'h1 << 30) | (32'h1 << 12) | (32'h1 << 8);

    typedef enum {K_ACCESS, K_EXCEPTION, K_MRET, K_LINES, K_PENDING, K_TRAP_OUT} step_kind_t;
    typedef enum {C_NONE, C_EQUAL, C_ABOVE_PREV} check_kind_t;

    // exp doubles as line bits, pending flag or trap vector; pc as expected epc
    typedef struct packed {
        step_kind_t  kind;
        csr_op_t     op;
        csr_addr_t   addr;
        csr_data_t   wdata;
        ecode_t      code;
        csr_data_t   pc;
        csr_data_t   tval;
        check_kind_t chk;
        csr_data_t   exp;
    } step_t;

    logic          clk;
    logic          rst;
    logic          issue_valid;
    csr_id_t       issue_id;
    csr_op_t       op;
    csr_addr_t     addr;
    csr_data_t     wdata;
    logic          ready;
    csr_id_t       oldest_id;
    logic          ack;
    logic          done;
    csr_id_t       wb_id;
    csr_data_t     rd;
    logic          exception_valid;
    ecode_t        exception_code;
    csr_data_t     exception_pc;
    csr_data_t     exception_tval;
    logic          mret;
    csr_data_t     trap_vector;
    csr_data_t     epc;
    logic          m_software;
    logic          m_timer;
    logic          m_external;
    logic          interrupt_pending;
    retire_count_t retire_count;

    step_t     steps[$];
    int        seed;
    int        mismatches;
    int        timeouts;
    int        idx;
    int        n;
    csr_id_t   cur_id;
    csr_data_t last_rd;

    tb_clock_gen #(.PERIOD(4), .RESET_CYCLES(2)) u_clock (.clk, .rst);

    csr_unit #(.COUNTER_W(64), .HART_ID(HART)) UUT (.*);

    //////////////////////////////////////////////////
    // Compare tasks
    task automatic check_data(input string what, input csr_data_t got, input csr_data_t exp);
        if (got !== exp) begin
            mismatches++;
            $display("mismatch at %0t ns: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_flag(input string what, input logic got, input logic exp);
        if (got !== exp) begin
            mismatches++;
            $display("mismatch at %0t ns: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    task automatic check_id(input string what, input csr_id_t got, input csr_id_t exp);
        if (got !== exp) begin
            mismatches++;
            $display("mismatch at %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic report_timeout(input string what);
        timeouts++;
        $display("timeout at %0t ns: %s within %0d cycles", $time, what, TIMEOUT);
    endtask

    //////////////////////////////////////////////////
    // Table entries
    function automatic void queue_access(input csr_op_t o, input csr_addr_t a,
                                         input csr_data_t d, input check_kind_t c,
                                         input csr_data_t e);
        step_t s;
        s = '0;
        s.kind  = K_ACCESS;
        s.op    = o;
        s.addr  = a;
        s.wdata = d;
        s.chk   = c;
        s.exp   = e;
        steps.push_back(s);
    endfunction

    function automatic void trap_entry(input ecode_t c, input csr_data_t pc,
                                       input csr_data_t tval);
        step_t s;
        s = '0;
        s.kind = K_EXCEPTION;
        s.code = c;
        s.pc   = pc;
        s.tval = tval;
        steps.push_back(s);
    endfunction

    function automatic void side_event(input step_kind_t k, input csr_data_t a,
                                       input csr_data_t b);
        step_t s;
        s = '0;
        s.kind = k;
        s.exp  = a;
        s.pc   = b;
        steps.push_back(s);
    endfunction

    task automatic build_table();
        csr_data_t x, y, junk, tv, pc, tval, cnt, hi;
        x    = $random(seed);
        y    = $random(seed);
        junk = $random(seed);
        tv   = $random(seed);
        pc   = $random(seed);
        tval = $random(seed);
        cnt  = $random(seed);
        hi   = $random(seed);
        // mscratch read-modify-write, no reset so first rd unchecked
        queue_access(CSR_RW, MSCRATCH, x, C_NONE, '0);
        queue_access(CSR_RS, MSCRATCH, '0, C_EQUAL, x);
        queue_access(CSR_RS, MSCRATCH, y, C_EQUAL, x);
        queue_access(CSR_RC, MSCRATCH, y, C_EQUAL, x | y);
        queue_access(CSR_RS, MSCRATCH, '0, C_EQUAL, x & ~y);
        // Identity registers
        queue_access(CSR_RS, MISA, '0, C_EQUAL, MISA_EXP);
        queue_access(CSR_RC, MVENDORID, '0, C_EQUAL, '0);
        queue_access(CSR_RW, MHARTID, junk, C_EQUAL, HART);
        queue_access(CSR_RS, MHARTID, '0, C_EQUAL, HART);
        // Exception entry and mret
        queue_access(CSR_RW, MTVEC, tv, C_EQUAL, '0);
        queue_access(CSR_RW, MSTATUS, 32'h8, C_EQUAL, '0);
        trap_entry(ILLEGAL_INST, pc, tval);
        queue_access(CSR_RS, MCAUSE, '0, C_EQUAL, 32'd2);
        queue_access(CSR_RS, MEPC, '0, C_EQUAL, pc & ~32'h3);
        queue_access(CSR_RS, MTVAL, '0, C_EQUAL, tval);
        queue_access(CSR_RS, MSTATUS, '0, C_EQUAL, 32'h80);
        side_event(K_TRAP_OUT, tv & ~32'h3, pc & ~32'h3);
        side_event(K_MRET, '0, '0);
        queue_access(CSR_RS, MSTATUS, '0, C_EQUAL, 32'h88);
        // mcause legality, code 10 is not implemented
        queue_access(CSR_RW, MCAUSE, 32'd11, C_EQUAL, 32'd2);
        queue_access(CSR_RW, MCAUSE, 32'd10, C_EQUAL, 32'd11);
        queue_access(CSR_RS, MCAUSE, '0, C_EQUAL, 32'd11);
        // Timer line against mie bit 7
        side_event(K_LINES, 32'h80, '0);
        side_event(K_PENDING, '0, '0);
        queue_access(CSR_RW, MIE, 32'h80, C_EQUAL, '0);
        side_event(K_PENDING, 32'h1, '0);
        queue_access(CSR_RS, MIP, '0, C_EQUAL, 32'h80);
        queue_access(CSR_RW, MIE, '1, C_EQUAL, 32'h80);
        queue_access(CSR_RS, MIE, '0, C_EQUAL, 32'h888);
        side_event(K_LINES, '0, '0);
        // Counters
        queue_access(CSR_RS, MCYCLE, '0, C_NONE, '0);
        queue_access(CSR_RS, MCYCLE, '0, C_ABOVE_PREV, '0);
        queue_access(CSR_RW, MINSTRET, cnt, C_NONE, '0);
        queue_access(CSR_RS, MINSTRET, '0, C_EQUAL, cnt);
        queue_access(CSR_RW, MCYCLEH, hi, C_NONE, '0);
        queue_access(CSR_RS, CYCLEH, '0, C_EQUAL, hi);
    endtask

    //////////////////////////////////////////////////
    // Stimulus, every task starts and ends on a falling edge
    task automatic issue_access(input step_t s);
        int w;
        w = 0;
        while (ready !== 1'b1 && w < TIMEOUT) begin
            @(negedge clk);
            w++;
        end
        if (ready !== 1'b1) begin
            report_timeout("ready did not rise for the next request");
            return;
        end
        issue_valid = 1'b1;
        issue_id    = cur_id;
        oldest_id   = cur_id;
        op          = s.op;
        addr        = s.addr;
        wdata       = s.wdata;
        // Accepted once ready drops
        w = 0;
        do begin
            @(negedge clk);
            w++;
        end while (ready === 1'b1 && w < TIMEOUT);
        issue_valid = 1'b0;
        if (ready === 1'b1) begin
            report_timeout("request was not accepted");
            return;
        end
        w = 0;
        while (done !== 1'b1 && w < TIMEOUT) begin
            @(negedge clk);
            w++;
        end
        if (done !== 1'b1) begin
            report_timeout("done did not rise");
            return;
        end
        check_id("wb_id", wb_id, cur_id);
        if (s.chk == C_EQUAL)
            check_data($sformatf("rd of csr %h", s.addr), rd, s.exp);
        else if (s.chk == C_ABOVE_PREV)
            check_flag("counter increase", rd > last_rd, 1'b1);
        last_rd = rd;
        ack = 1'b1;
        @(negedge clk);
        ack = 1'b0;
        cur_id = cur_id + 3'd1;
    endtask

    task automatic apply_step(input step_t s);
        case (s.kind)
            K_ACCESS: issue_access(s);
            K_EXCEPTION: begin
                exception_valid = 1'b1;
                exception_code  = s.code;
                exception_pc    = s.pc;
                exception_tval  = s.tval;
                @(negedge clk);
                exception_valid = 1'b0;
            end
            K_MRET: begin
                mret = 1'b1;
                @(negedge clk);
                mret = 1'b0;
            end
            K_LINES: begin
                m_software = s.exp[M_SOFTWARE_INTERRUPT];
                m_timer    = s.exp[M_TIMER_INTERRUPT];
                m_external = s.exp[M_EXTERNAL_INTERRUPT];
                // mip lags the lines by one cycle
                repeat (2) @(negedge clk);
            end
            K_PENDING: check_flag("interrupt_pending", interrupt_pending, s.exp[0]);
            default: begin
                check_data("trap_vector", trap_vector, s.exp);
                check_data("epc", epc, s.pc);
            end
        endcase
    endtask

    initial begin
        issue_valid     = 1'b0;
        issue_id        = '0;
        op              = CSR_RW;
        addr            = '0;
        wdata           = '0;
        oldest_id       = '0;
        ack             = 1'b0;
        exception_valid = 1'b0;
        exception_code  = '0;
        exception_pc    = '0;
        exception_tval  = '0;
        mret            = 1'b0;
        m_software      = 1'b0;
        m_timer         = 1'b0;
        m_external      = 1'b0;
        retire_count    = '0;
        seed            = 32'h99dd6e95;
        mismatches      = 0;
        timeouts        = 0;
        cur_id          = '0;
        last_rd         = '0;
        build_table();

        n = 0;
        while (rst !== 1'b0 && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (rst !== 1'b0)
            report_timeout("reset was not released");
        else begin
            check_flag("done after reset", done, 1'b0);
            check_flag("ready after reset", ready, 1'b1);
        end

        for (idx = 0; idx < steps.size() && timeouts == 0; idx++)
            apply_step(steps[idx]);

        $display("checks finished: %0d mismatches, %0d timeouts", mismatches, timeouts);
        if (mismatches == 0 && timeouts == 0)
            $display(">>> PASS");
        else
            $display(">>> FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// ==== tb_clock_gen.sv ====
/* Testbench clock and reset */
`timescale 1ns/1ns
`default_nettype none

module tb_clock_gen #(
    parameter int PERIOD       = 4,
    parameter int RESET_CYCLES = 2
) (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    // Released on a falling edge, clear of the sampling edge
    initial begin
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
    end

endmodule

`default_nettype wire

// ==== csr_unit.sv ====
/* Machine mode CSR unit */
`timescale 1ns/1ns
`default_nettype none

module csr_unit #(
    parameter int COUNTER_W = 64,
    parameter int HART_ID   = 0
) (
    input  logic                   clk,
    input  logic                   rst,
    // Issue
    input  logic                   issue_valid,
    input  csr_pkg::csr_id_t       issue_id,
    input  csr_pkg::csr_op_t       op,
    input  csr_pkg::csr_addr_t     addr,
    input  csr_pkg::csr_data_t     wdata,
    output logic                   ready,
    input  csr_pkg::csr_id_t       oldest_id,
    // Writeback
    input  logic                   ack,
    output logic                   done,
    output csr_pkg::csr_id_t       wb_id,
    output csr_pkg::csr_data_t     rd,
    // Traps
    input  logic                   exception_valid,
    input  csr_pkg::ecode_t        exception_code,
    input  csr_pkg::csr_data_t     exception_pc,
    input  csr_pkg::csr_data_t     exception_tval,
    input  logic                   mret,
    output csr_pkg::csr_data_t     trap_vector,
    output csr_pkg::csr_data_t     epc,
    // Interrupts and retire
    input  logic                   m_software,
    input  logic                   m_timer,
    input  logic                   m_external,
    output logic                   interrupt_pending,
    input  csr_pkg::retire_count_t retire_count
);
    import csr_pkg::*;

    csr_addr_t cur_addr;
    csr_data_t read_value;
    logic      write_legal;
    logic      wr_en;
    csr_addr_t wr_addr;
    csr_data_t wr_data;

    csr_data_t mstatus, mtvec, mepc, mcause;
    csr_data_t mtval, mscratch, mie, mip;
    logic [COUNTER_W-1:0] mcycle;
    logic [COUNTER_W-1:0] minstret;

    csr_access_ctrl u_ctrl (
        .clk, .rst, .issue_valid, .issue_id, .op, .addr, .wdata, .ready,
        .oldest_id, .ack, .done, .wb_id, .rd, .cur_addr, .read_value,
        .write_legal, .wr_en, .wr_addr, .wr_data
    );

    csr_read_mux #(
        .COUNTER_W (COUNTER_W),
        .HART_ID   (HART_ID)
    ) u_read_mux (
        .addr (cur_addr),
        .mstatus, .mtvec, .mepc, .mcause, .mtval, .mscratch, .mie, .mip,
        .mcycle, .minstret, .read_value, .write_legal
    );

    csr_trap_regs u_trap_regs (
        .clk, .rst, .wr_en, .wr_addr, .wr_data,
        .exception_valid, .exception_code, .exception_pc, .exception_tval,
        .mret, .m_software, .m_timer, .m_external,
        .mstatus, .mtvec, .mepc, .mcause, .mtval, .mscratch, .mie, .mip,
        .trap_vector, .epc, .interrupt_pending
    );

    csr_counters #(
        .COUNTER_W (COUNTER_W)
    ) u_counters (
        .clk, .rst, .wr_en, .wr_addr, .wr_data, .retire_count,
        .mcycle, .minstret
    );

endmodule

`default_nettype wire

// ==== csr_read_mux.sv ====
/* CSR read select */
`timescale 1ns/1ns
`default_nettype none

module csr_read_mux #(
    parameter int COUNTER_W = 64,
    parameter int HART_ID   = 0
) (
    input  csr_pkg::csr_addr_t   addr,
    input  csr_pkg::csr_data_t   mstatus,
    input  csr_pkg::csr_data_t   mtvec,
    input  csr_pkg::csr_data_t   mepc,
    input  csr_pkg::csr_data_t   mcause,
    input  csr_pkg::csr_data_t   mtval,
    input  csr_pkg::csr_data_t   mscratch,
    input  csr_pkg::csr_data_t   mie,
    input  csr_pkg::csr_data_t   mip,
    input  logic [COUNTER_W-1:0] mcycle,
    input  logic [COUNTER_W-1:0] minstret,
    output csr_pkg::csr_data_t   read_value,
    output logic                 write_legal
);
    import csr_pkg::*;

    //////////////////////////////////////////////////
    // Identity constants
    // RV32 (mxl 1), base I plus M extension
    localparam csr_data_t MISA_VAL      = 32'h4000_1100;
    localparam csr_data_t VENDOR_VAL    = '0;
    localparam csr_data_t ARCH_VAL      = '0;
    localparam csr_data_t IMP_VAL       = 32'h0000_0001;
    localparam csr_data_t HART_VAL      = csr_data_t'(HART_ID);

    csr_data_t cycle_hi;
    csr_data_t instret_hi;

    assign cycle_hi   = csr_data_t'(mcycle[COUNTER_W-1:XLEN]);
    assign instret_hi = csr_data_t'(minstret[COUNTER_W-1:XLEN]);

    always_comb begin
        case (addr)
            MISA:      read_value = MISA_VAL;
            MVENDORID: read_value = VENDOR_VAL;
            MARCHID:   read_value = ARCH_VAL;
            MIMPID:    read_value = IMP_VAL;
            MHARTID:   read_value = HART_VAL;
            MSTATUS:   read_value = mstatus;
            MIE:       read_value = mie;
            MTVEC:     read_value = mtvec;
            MSCRATCH:  read_value = mscratch;
            MEPC:      read_value = mepc;
            MCAUSE:    read_value = mcause;
            MTVAL:     read_value = mtval;
            MIP:       read_value = mip;
            // time has no timer of its own and follows the cycle count
            MCYCLE, CYCLE, TIME:       read_value = mcycle[XLEN-1:0];
            MINSTRET, INSTRET:         read_value = minstret[XLEN-1:0];
            MCYCLEH, CYCLEH, TIMEH:    read_value = cycle_hi;
            MINSTRETH, INSTRETH:       read_value = instret_hi;
            default:   read_value = '0;
        endcase
    end

    // Top address bits 11 mark a read-only CSR
    assign write_legal = (addr[11:10] != 2'b11);

endmodule

`default_nettype wire

// ==== csr_counters.sv ====
/* Cycle and instret counters */
`timescale 1ns/1ns
`default_nettype none

module csr_counters #(
    parameter int COUNTER_W = 64
) (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     wr_en,
    input  csr_pkg::csr_addr_t       wr_addr,
    input  csr_pkg::csr_data_t       wr_data,
    input  csr_pkg::retire_count_t   retire_count,
    output logic [COUNTER_W-1:0]     mcycle,
    output logic [COUNTER_W-1:0]     minstret
);
    import csr_pkg::*;

    typedef logic [COUNTER_W-1:0] count_t;

    count_t mcycle_next;
    count_t minstret_next;

    // A written half replaces the count, no increment that cycle
    function automatic count_t next_count(input count_t cur, input logic lo_hit,
                                          input logic hi_hit, input count_t inc);
        count_t result;
        result = (lo_hit || hi_hit) ? cur : cur + inc;
        if (lo_hit)
            result[XLEN-1:0] = wr_data;
        if (hi_hit)
            result[COUNTER_W-1:XLEN] = wr_data[COUNTER_W-XLEN-1:0];
        return result;
    endfunction

    always_comb begin
        mcycle_next   = next_count(mcycle, wr_en && (wr_addr == MCYCLE),
                                   wr_en && (wr_addr == MCYCLEH), count_t'(1));
        minstret_next = next_count(minstret, wr_en && (wr_addr == MINSTRET),
                                   wr_en && (wr_addr == MINSTRETH),
                                   count_t'(retire_count));
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            mcycle   <= '0;
            minstret <= '0;
        end else begin
            mcycle   <= mcycle_next;
            minstret <= minstret_next;
        end
    end

endmodule

`default_nettype wire

// ==== csr_trap_regs.sv ====
/* Machine trap and interrupt registers */
`timescale 1ns/1ns
`default_nettype none

module csr_trap_regs (
    input  logic               clk,
    input  logic               rst,
    input  logic               wr_en,
    input  csr_pkg::csr_addr_t wr_addr,
    input  csr_pkg::csr_data_t wr_data,
    input  logic               exception_valid,
    input  csr_pkg::ecode_t    exception_code,
    input  csr_pkg::csr_data_t exception_pc,
    input  csr_pkg::csr_data_t exception_tval,
    input  logic               mret,
    input  logic               m_software,
    input  logic               m_timer,
    input  logic               m_external,
    output csr_pkg::csr_data_t mstatus,
    output csr_pkg::csr_data_t mtvec,
    output csr_pkg::csr_data_t mepc,
    output csr_pkg::csr_data_t mcause,
    output csr_pkg::csr_data_t mtval,
    output csr_pkg::csr_data_t mscratch,
    output csr_pkg::csr_data_t mie,
    output csr_pkg::csr_data_t mip,
    output csr_pkg::csr_data_t trap_vector,
    output csr_pkg::csr_data_t epc,
    output logic               interrupt_pending
);
    import csr_pkg::*;

    localparam int MIE_BIT  = 3;
    localparam int MPIE_BIT = 7;
    localparam csr_data_t IRQ_MASK = (csr_data_t'(1) << M_SOFTWARE_INTERRUPT)
                                   | (csr_data_t'(1) << M_TIMER_INTERRUPT)
                                   | (csr_data_t'(1) << M_EXTERNAL_INTERRUPT);

    logic   status_mie;
    logic   status_mpie;
    logic   cause_irq;
    ecode_t cause_code;

    function automatic logic hit(input csr_addr_t a);
        return wr_en && (wr_addr == a);
    endfunction

    // Only codes this hart can actually raise
    function automatic logic cause_legal(input logic irq, input ecode_t code);
        if (irq)
            return code inside {M_SOFTWARE_INTERRUPT, M_TIMER_INTERRUPT,
                                M_EXTERNAL_INTERRUPT};
        return code inside {INST_ADDR_MISALIGNED, INST_ACCESS_FAULT, ILLEGAL_INST,
                            BREAK, LOAD_ADDR_MISALIGNED, LOAD_FAULT,
                            STORE_AMO_ADDR_MISALIGNED, STORE_AMO_FAULT, ECALL_M};
    endfunction

    //////////////////////////////////////////////////
    // mstatus, exception entry beats a software write
    always_ff @(posedge clk) begin
        if (rst) begin
            status_mie  <= 1'b0;
            status_mpie <= 1'b0;
        end else if (exception_valid) begin
            status_mpie <= status_mie;
            status_mie  <= 1'b0;
        end else if (mret) begin
            status_mie  <= status_mpie;
            status_mpie <= 1'b1;
        end else if (hit(MSTATUS)) begin
            status_mie  <= wr_data[MIE_BIT];
            status_mpie <= wr_data[MPIE_BIT];
        end
    end

    always_comb begin
        mstatus           = '0;
        mstatus[MIE_BIT]  = status_mie;
        mstatus[MPIE_BIT] = status_mpie;
    end

    //////////////////////////////////////////////////
    // Vector, cause and trap payload
    always_ff @(posedge clk) begin
        if (rst)
            mtvec <= '0;
        else if (hit(MTVEC))
            mtvec <= {wr_data[XLEN-1:2], 2'b00};
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            cause_irq  <= 1'b0;
            cause_code <= '0;
        end else if (exception_valid) begin
            cause_irq  <= 1'b0;
            cause_code <= exception_code;
        end else if (hit(MCAUSE) && cause_legal(wr_data[XLEN-1], wr_data[ECODE_W-1:0])) begin
            cause_irq  <= wr_data[XLEN-1];
            cause_code <= wr_data[ECODE_W-1:0];
        end
    end

    assign mcause = {cause_irq, {(XLEN-1-ECODE_W){1'b0}}, cause_code};

    always_ff @(posedge clk) begin
        if (exception_valid) begin
            mepc  <= {exception_pc[XLEN-1:2], 2'b00};
            mtval <= exception_tval;
        end else begin
            if (hit(MEPC))
                mepc <= {wr_data[XLEN-1:2], 2'b00};
            if (hit(MTVAL))
                mtval <= wr_data;
        end
        if (hit(MSCRATCH))
            mscratch <= wr_data;
    end

    //////////////////////////////////////////////////
    // Interrupt enable and pending
    always_ff @(posedge clk) begin
        if (rst) begin
            mie <= '0;
            mip <= '0;
        end else begin
            if (hit(MIE))
                mie <= wr_data & IRQ_MASK;
            mip                       <= '0;
            mip[M_SOFTWARE_INTERRUPT] <= m_software;
            mip[M_TIMER_INTERRUPT]    <= m_timer;
            mip[M_EXTERNAL_INTERRUPT] <= m_external;
        end
    end

    assign interrupt_pending = |(mip & mie);
    assign trap_vector       = mtvec;
    assign epc               = mepc;

    a_no_exc_and_mret: assert property (@(posedge clk) disable iff (rst)
        !(exception_valid && mret));

endmodule

`default_nettype wire

// ==== csr_access_ctrl.sv ====
/* CSR access sequencing */
`timescale 1ns/1ns
`default_nettype none

module csr_access_ctrl (
    input  logic               clk,
    input  logic               rst,
    input  logic               issue_valid,
    input  csr_pkg::csr_id_t   issue_id,
    input  csr_pkg::csr_op_t   op,
    input  csr_pkg::csr_addr_t addr,
    input  csr_pkg::csr_data_t wdata,
    output logic               ready,
    input  csr_pkg::csr_id_t   oldest_id,
    input  logic               ack,
    output logic               done,
    output csr_pkg::csr_id_t   wb_id,
    output csr_pkg::csr_data_t rd,
    output csr_pkg::csr_addr_t cur_addr,
    input  csr_pkg::csr_data_t read_value,
    input  logic               write_legal,
    output logic               wr_en,
    output csr_pkg::csr_addr_t wr_addr,
    output csr_pkg::csr_data_t wr_data
);
    import csr_pkg::*;

    ctrl_state_t state;
    csr_op_t     cur_op;
    csr_data_t   cur_wdata;
    csr_data_t   new_value;
    logic        commit;
    logic        write_skip;

    assign ready = (state == IDLE);

    // Held request goes once it is the oldest in flight
    assign commit = (state == WAIT_OLDEST) && (oldest_id == wb_id);

    // Set or clear with no bits is a pure read
    assign write_skip = (cur_op != CSR_RW) && (cur_wdata == '0);

    always_comb begin
        case (cur_op)
            CSR_RS:  new_value = read_value | cur_wdata;
            CSR_RC:  new_value = read_value & ~cur_wdata;
            default: new_value = cur_wdata;
        endcase
    end

    //////////////////////////////////////////////////
    // Request latch
    always_ff @(posedge clk) begin
        if (issue_valid && ready) begin
            wb_id     <= issue_id;
            cur_op    <= op;
            cur_addr  <= addr;
            cur_wdata <= wdata;
        end
    end

    assign wr_addr = cur_addr;

    always_ff @(posedge clk) begin
        if (commit) begin
            rd      <= read_value;
            wr_data <= new_value;
        end
    end

    //////////////////////////////////////////////////
    // Control FSM
    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
            done  <= 1'b0;
            wr_en <= 1'b0;
        end else begin
            wr_en <= 1'b0;
            case (state)
                IDLE: begin
                    if (issue_valid)
                        state <= WAIT_OLDEST;
                end
                WAIT_OLDEST: begin
                    if (commit) begin
                        state <= RESULT;
                        done  <= 1'b1;
                        wr_en <= write_legal && !write_skip;
                    end
                end
                RESULT: begin
                    if (ack) begin
                        state <= IDLE;
                        done  <= 1'b0;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // Writeback result holds while the core withholds ack
    a_done_hold: assert property (@(posedge clk) disable iff (rst)
        done && !ack |=> done && $stable(rd) && $stable(wb_id) && !ready);

    // Register write strobe only ever comes with a fresh writeback
    a_wr_with_done: assert property (@(posedge clk) disable iff (rst)
        wr_en |-> $rose(done));

endmodule

`default_nettype wire

// ==== csr_pkg.sv ====
/* CSR unit shared definitions */
`default_nettype none

package csr_pkg;

    //////////////////////////////////////////////////
    // Widths and types
    localparam int XLEN    = 32;
    localparam int ID_W    = 3;
    localparam int ECODE_W = 5;

    typedef logic [XLEN-1:0]    csr_data_t;
    typedef logic [11:0]        csr_addr_t;
    typedef logic [ID_W-1:0]    csr_id_t;
    typedef logic [1:0]         retire_count_t;
    typedef logic [ECODE_W-1:0] ecode_t;

    // Matches funct3[1:0] of the CSR instructions
    typedef enum logic [1:0] {
        CSR_RW = 2'b01,
        CSR_RS = 2'b10,
        CSR_RC = 2'b11
    } csr_op_t;

    typedef enum logic [1:0] {
        IDLE,
        WAIT_OLDEST,
        RESULT
    } ctrl_state_t;

    //////////////////////////////////////////////////
    // Machine identity and trap registers
    localparam csr_addr_t MVENDORID = 12'hF11;
    localparam csr_addr_t MARCHID   = 12'hF12;
    localparam csr_addr_t MIMPID    = 12'hF13;
    localparam csr_addr_t MHARTID   = 12'hF14;
    localparam csr_addr_t MSTATUS   = 12'h300;
    localparam csr_addr_t MISA      = 12'h301;
    localparam csr_addr_t MIE       = 12'h304;
    localparam csr_addr_t MTVEC     = 12'h305;
    localparam csr_addr_t MSCRATCH  = 12'h340;
    localparam csr_addr_t MEPC      = 12'h341;
    localparam csr_addr_t MCAUSE    = 12'h342;
    localparam csr_addr_t MTVAL     = 12'h343;
    localparam csr_addr_t MIP       = 12'h344;

    // Counters and their user aliases
    localparam csr_addr_t MCYCLE    = 12'hB00;
    localparam csr_addr_t MINSTRET  = 12'hB02;
    localparam csr_addr_t MCYCLEH   = 12'hB80;
    localparam csr_addr_t MINSTRETH = 12'hB82;
    localparam csr_addr_t CYCLE     = 12'hC00;
    localparam csr_addr_t TIME      = 12'hC01;
    localparam csr_addr_t INSTRET   = 12'hC02;
    localparam csr_addr_t CYCLEH    = 12'hC80;
    localparam csr_addr_t TIMEH     = 12'hC81;
    localparam csr_addr_t INSTRETH  = 12'hC82;

    //////////////////////////////////////////////////
    // Exception codes
    localparam ecode_t INST_ADDR_MISALIGNED      = 5'd0;
    localparam ecode_t INST_ACCESS_FAULT         = 5'd1;
    localparam ecode_t ILLEGAL_INST              = 5'd2;
    localparam ecode_t BREAK                     = 5'd3;
    localparam ecode_t LOAD_ADDR_MISALIGNED      = 5'd4;
    localparam ecode_t LOAD_FAULT                = 5'd5;
    localparam ecode_t STORE_AMO_ADDR_MISALIGNED = 5'd6;
    localparam ecode_t STORE_AMO_FAULT           = 5'd7;
    localparam ecode_t ECALL_M                   = 5'd11;

    // Interrupt codes, also the mie and mip bit positions
    localparam ecode_t M_SOFTWARE_INTERRUPT = 5'd3;
    localparam ecode_t M_TIMER_INTERRUPT    = 5'd7;
    localparam ecode_t M_EXTERNAL_INTERRUPT = 5'd11;

endpackage

`default_nettype wire
